//--- Makefile
OBJ_DIR = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module genesis_cart_tb -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/Vgenesis_cart_tb +verilator+error+limit+100 | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- files.f
+incdir+hw
hw/genesis_pkg.sv
hw/cart_load_fsm.sv
hw/header_region_decoder.sv
hw/cart_quirk_lookup.sv
hw/core_settings_regs.sv
hw/reset_hold_timer.sv
hw/genesis_cart_top.sv
verification/genesis_cart_chk.sv
verification/genesis_cart_tb.sv

//--- hw/cart_load_fsm.sv
//////////////////////////////////////////////////////////////////////
// cartridge load state machine
// follows the rom download, pulses the decoder clear and region latch
// and keeps the core in reset while the new region is applied
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module cart_load_fsm (
	input  logic clk_sys,
	input  logic pll_core_locked,
	input  logic cart_download,
	input  logic header_done,
	output logic load_start,
	output logic region_latch,
	output logic region_hold
);

	typedef enum logic [1:0] {
		IDLE,
		LOADING,
		REGION_APPLY
	} state_t;

	state_t state;

	always_ff @(posedge clk_sys or negedge pll_core_locked) begin
		if (!pll_core_locked) begin
			state        <= IDLE;
			load_start   <= 1'b0;
			region_latch <= 1'b0;
		end else begin
			load_start   <= 1'b0; // both are single cycle strobes
			region_latch <= 1'b0;
			case (state)
				IDLE: if (cart_download) begin
					state      <= LOADING;
					load_start <= 1'b1;
				end
				LOADING: if (!cart_download) begin
					state <= IDLE; // aborted before the header end
				end else if (header_done) begin
					state        <= REGION_APPLY;
					region_latch <= 1'b1;
				end
				REGION_APPLY: if (!cart_download) state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// reset held until the rest of the rom is in
	assign region_hold = (state == REGION_APPLY);

endmodule

//--- hw/cart_quirk_lookup.sv
//////////////////////////////////////////////////////////////////////
// cartridge quirk lookup
// collects the serial number from the rom header and raises the
// compatibility flag that the table lists for it
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "genesis_defines.svh"

module cart_quirk_lookup (
	input  logic                  clk_sys,
	input  logic                  pll_core_locked,
	input  logic                  cart_download,
	input  logic                  rom_wr,
	input  genesis_pkg::rom_addr_t rom_addr,
	input  genesis_pkg::rom_word_t rom_data,
	input  logic                  load_start,
	output logic                  sram_quirk,
	output logic                  eeprom_quirk,
	output logic                  noram_quirk,
	output logic                  fifo_quirk,
	output logic                  svp_quirk,
	output logic                  fmbusy_quirk
);

	genesis_pkg::cart_id_t cart_id;
	logic                  wr_hit;

	assign wr_hit = rom_wr & cart_download;

	// serial assembly, each word arrives byte swapped
	always_ff @(posedge clk_sys) begin
		if (wr_hit) begin
			if (rom_addr == `GEN_HDR_ID0) cart_id[63:56] <= rom_data[15:8];
			if (rom_addr == `GEN_HDR_ID1) cart_id[55:40] <= {rom_data[7:0], rom_data[15:8]};
			if (rom_addr == `GEN_HDR_ID2) cart_id[39:24] <= {rom_data[7:0], rom_data[15:8]};
			if (rom_addr == `GEN_HDR_ID3) cart_id[23:8]  <= {rom_data[7:0], rom_data[15:8]};
			if (rom_addr == `GEN_HDR_ID4) cart_id[7:0]   <= rom_data[7:0];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// quirk table
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge pll_core_locked) begin
		if (!pll_core_locked) begin
			{sram_quirk, eeprom_quirk, noram_quirk} <= 3'b000;
			{fifo_quirk, svp_quirk, fmbusy_quirk}   <= 3'b000;
		end else if (load_start) begin
			{sram_quirk, eeprom_quirk, noram_quirk} <= 3'b000; // new cart
			{fifo_quirk, svp_quirk, fmbusy_quirk}   <= 3'b000;
		end else if (wr_hit && rom_addr == `GEN_HDR_ID_DONE) begin
			case (cart_id)
				"T-081276", "T-81406 ": sram_quirk   <= 1'b1; // battery ram mapped late
				"MK-1215 ", "G-4060  ": eeprom_quirk <= 1'b1;
				"T-113016":             noram_quirk  <= 1'b1; // fake ram check
				"T-89016 ":             fifo_quirk   <= 1'b1;
				"MK-1229 ":             svp_quirk    <= 1'b1;
				"T-35036 ":             fmbusy_quirk <= 1'b1;
				default:                ;
			endcase
		end
	end

endmodule

//--- hw/core_settings_regs.sv
//////////////////////////////////////////////////////////////////////
// core option registers
// written by the host bridge, region readback and reset request
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "genesis_defines.svh"

module core_settings_regs (
	input  logic                     clk_sys,
	input  logic                     pll_core_locked,
	input  logic                     bridge_wr,
	input  genesis_pkg::bridge_word_t bridge_addr,
	input  genesis_pkg::bridge_word_t bridge_wr_data,
	input  genesis_pkg::region_e     region_req,
	output genesis_pkg::bridge_word_t bridge_rd_data,
	output logic [1:0]               cpu_turbo,
	output logic [1:0]               audio_filter,
	output logic                     multitap_en,
	output logic                     ar_correction_en,
	output logic                     composite_en,
	output logic                     obj_limit_high,
	output logic                     fm_enable,
	output logic                     psg_enable,
	output logic                     hifi_pcm_en,
	output logic                     fm_chip,
	output logic                     hold_req
);

	always_ff @(posedge clk_sys or negedge pll_core_locked) begin
		if (!pll_core_locked) begin
			cpu_turbo        <= `GEN_DEF_TURBO;
			audio_filter     <= `GEN_DEF_FILTER;
			multitap_en      <= `GEN_DEF_MULTITAP;
			ar_correction_en <= `GEN_DEF_AR_CORR;
			composite_en     <= `GEN_DEF_COMPOSITE;
			obj_limit_high   <= `GEN_DEF_OBJ_LIMIT;
			fm_enable        <= `GEN_DEF_FM;
			psg_enable       <= `GEN_DEF_PSG;
			hifi_pcm_en      <= `GEN_DEF_HIFI;
			fm_chip          <= `GEN_DEF_FM_CHIP;
		end else if (bridge_wr) begin
			case (bridge_addr)
				`GEN_ADDR_TURBO:     cpu_turbo        <= bridge_wr_data[1:0];
				`GEN_ADDR_FILTER:    audio_filter     <= bridge_wr_data[1:0];
				`GEN_ADDR_MULTITAP:  multitap_en      <= bridge_wr_data[0];
				`GEN_ADDR_AR_CORR:   ar_correction_en <= bridge_wr_data[0];
				`GEN_ADDR_COMPOSITE: composite_en     <= bridge_wr_data[0];
				`GEN_ADDR_OBJ_LIMIT: obj_limit_high   <= bridge_wr_data[0];
				`GEN_ADDR_FM:        fm_enable        <= bridge_wr_data[0];
				`GEN_ADDR_PSG:       psg_enable       <= bridge_wr_data[0];
				`GEN_ADDR_HIFI:      hifi_pcm_en      <= bridge_wr_data[0];
				`GEN_ADDR_FM_CHIP:   fm_chip          <= bridge_wr_data[0];
				default:             ;
			endcase
		end
	end

	// any nonzero value restarts the hold timer
	assign hold_req = bridge_wr && (bridge_addr == `GEN_ADDR_RESET) && (bridge_wr_data != '0);

	// only the region is readable
	always_comb begin
		if (bridge_addr == `GEN_ADDR_REGION) bridge_rd_data = genesis_pkg::bridge_word_t'(region_req);
		else bridge_rd_data = '0;
	end

endmodule

//--- hw/genesis_cart_top.sv
//////////////////////////////////////////////////////////////////////
// genesis cartridge control top level
// settings, header region detect, quirk lookup and core reset
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module genesis_cart_top (
	input  logic                     clk_sys,
	input  logic                     pll_core_locked,
	input  logic                     bridge_wr,
	input  genesis_pkg::bridge_word_t bridge_addr,
	input  genesis_pkg::bridge_word_t bridge_wr_data,
	output genesis_pkg::bridge_word_t bridge_rd_data,
	input  logic                     cart_download,
	input  logic                     rom_wr,
	input  genesis_pkg::rom_addr_t    rom_addr,
	input  genesis_pkg::rom_word_t    rom_data,
	output genesis_pkg::region_e     region_req,
	output logic                     sram_quirk,
	output logic                     eeprom_quirk,
	output logic                     noram_quirk,
	output logic                     fifo_quirk,
	output logic                     svp_quirk,
	output logic                     fmbusy_quirk,
	output logic [1:0]               cpu_turbo,
	output logic [1:0]               audio_filter,
	output logic                     multitap_en,
	output logic                     ar_correction_en,
	output logic                     composite_en,
	output logic                     obj_limit_high,
	output logic                     fm_enable,
	output logic                     psg_enable,
	output logic                     hifi_pcm_en,
	output logic                     fm_chip,
	output logic                     core_reset_n
);

	logic header_done;
	logic load_start;
	logic region_latch;
	logic region_hold;
	logic hold_req;
	logic timer_busy;

	//////////////////////////////////////////////////////////////////////
	// rom download path
	//////////////////////////////////////////////////////////////////////

	cart_load_fsm u_cart_load_fsm (
		.clk_sys(clk_sys), .pll_core_locked(pll_core_locked),
		.cart_download(cart_download), .header_done(header_done),
		.load_start(load_start), .region_latch(region_latch), .region_hold(region_hold)
	);

	header_region_decoder u_header_region_decoder (
		.clk_sys(clk_sys), .pll_core_locked(pll_core_locked),
		.cart_download(cart_download), .rom_wr(rom_wr),
		.rom_addr(rom_addr), .rom_data(rom_data),
		.load_start(load_start), .region_latch(region_latch),
		.header_done(header_done), .region_req(region_req)
	);

	cart_quirk_lookup u_cart_quirk_lookup (
		.clk_sys(clk_sys), .pll_core_locked(pll_core_locked),
		.cart_download(cart_download), .rom_wr(rom_wr),
		.rom_addr(rom_addr), .rom_data(rom_data), .load_start(load_start),
		.sram_quirk(sram_quirk), .eeprom_quirk(eeprom_quirk), .noram_quirk(noram_quirk),
		.fifo_quirk(fifo_quirk), .svp_quirk(svp_quirk), .fmbusy_quirk(fmbusy_quirk)
	);

	//////////////////////////////////////////////////////////////////////
	// host settings and reset
	//////////////////////////////////////////////////////////////////////

	core_settings_regs u_core_settings_regs (
		.clk_sys(clk_sys), .pll_core_locked(pll_core_locked),
		.bridge_wr(bridge_wr), .bridge_addr(bridge_addr), .bridge_wr_data(bridge_wr_data),
		.region_req(region_req), .bridge_rd_data(bridge_rd_data),
		.cpu_turbo(cpu_turbo), .audio_filter(audio_filter),
		.multitap_en(multitap_en), .ar_correction_en(ar_correction_en),
		.composite_en(composite_en), .obj_limit_high(obj_limit_high),
		.fm_enable(fm_enable), .psg_enable(psg_enable),
		.hifi_pcm_en(hifi_pcm_en), .fm_chip(fm_chip), .hold_req(hold_req)
	);

	reset_hold_timer u_reset_hold_timer (
		.clk_sys(clk_sys), .pll_core_locked(pll_core_locked),
		.hold_req(hold_req), .busy(timer_busy)
	);

	// core stays in reset out of power-up until the first clean cycle
	always_ff @(posedge clk_sys or negedge pll_core_locked) begin
		if (!pll_core_locked) begin
			core_reset_n <= 1'b0;
		end else begin
			core_reset_n <= ~(region_hold | timer_busy);
		end
	end

endmodule

//--- hw/genesis_defines.svh
//////////////////////////////////////////////////////////////////////
// genesis cartridge control constants
// bridge setting addresses, rom header offsets and reset defaults
//////////////////////////////////////////////////////////////////////
`ifndef GENESIS_DEFINES_SVH
`define GENESIS_DEFINES_SVH

// bridge setting addresses
`define GEN_ADDR_MULTITAP   32'h0000_0000
`define GEN_ADDR_AR_CORR    32'h0000_0010
`define GEN_ADDR_COMPOSITE  32'h0000_0020
`define GEN_ADDR_OBJ_LIMIT  32'h0000_0030
`define GEN_ADDR_FM         32'h0000_0040
`define GEN_ADDR_PSG        32'h0000_0050
`define GEN_ADDR_HIFI       32'h0000_0060
`define GEN_ADDR_RESET      32'h0000_0070
`define GEN_ADDR_FM_CHIP    32'h00A0_0000
`define GEN_ADDR_TURBO      32'h00C0_0000
`define GEN_ADDR_REGION     32'h00E0_0000
`define GEN_ADDR_FILTER     32'h00F0_0000

// rom header byte offsets
`define GEN_HDR_REGION0     25'h1F0
`define GEN_HDR_REGION1     25'h1F2
`define GEN_HDR_END         25'h200
`define GEN_HDR_ID0         25'h182 // serial starts in the high byte
`define GEN_HDR_ID1         25'h184
`define GEN_HDR_ID2         25'h186
`define GEN_HDR_ID3         25'h188
`define GEN_HDR_ID4         25'h18A // last serial char in the low byte
`define GEN_HDR_ID_DONE     25'h18C

`define GEN_RESET_HOLD_CYCLES 16

// power-up option values
`define GEN_DEF_MULTITAP    1'b0
`define GEN_DEF_AR_CORR     1'b0
`define GEN_DEF_COMPOSITE   1'b0
`define GEN_DEF_OBJ_LIMIT   1'b1
`define GEN_DEF_FM          1'b1
`define GEN_DEF_PSG         1'b1
`define GEN_DEF_HIFI        1'b1
`define GEN_DEF_FM_CHIP     1'b0
`define GEN_DEF_TURBO       2'd0
`define GEN_DEF_FILTER      2'd0

`endif

//--- hw/genesis_pkg.sv
//////////////////////////////////////////////////////////////////////
// genesis cartridge control types
// region code, rom download word and address, cart serial, bridge word
//////////////////////////////////////////////////////////////////////
package genesis_pkg;

	// console region as handed to the core
	typedef enum logic [1:0] {
		JP = 2'd0,
		US = 2'd1,
		EU = 2'd2
	} region_e;

	// downloaded rom word, low byte holds the earlier character
	typedef logic [15:0] rom_word_t;

	// byte address of a downloaded word
	typedef logic [24:0] rom_addr_t;

	// eight ascii chars, first one in the top byte
	typedef logic [63:0] cart_id_t;

	// bridge address and data
	typedef logic [31:0] bridge_word_t;

endpackage

//--- hw/header_region_decoder.sv
//////////////////////////////////////////////////////////////////////
// rom header region decoder
// watches the region field of the downloaded header and picks the
// region the core runs in
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "genesis_defines.svh"

module header_region_decoder (
	input  logic                  clk_sys,
	input  logic                  pll_core_locked,
	input  logic                  cart_download,
	input  logic                  rom_wr,
	input  genesis_pkg::rom_addr_t rom_addr,
	input  genesis_pkg::rom_word_t rom_data,
	input  logic                  load_start,
	input  logic                  region_latch,
	output logic                  header_done,
	output genesis_pkg::region_e  region_req
);

	// {j, u, e} per region letter
	function automatic logic [2:0] letter_hit(input logic [7:0] ch);
		case (ch)
			"J":     return 3'b100;
			"U":     return 3'b010;
			"E":     return 3'b001;
			default: return 3'b000;
		endcase
	endfunction

	logic       wr_hit;
	logic [2:0] flags; // j u e
	logic [2:0] flags_nxt;
	logic [2:0] lo_hit;
	logic [2:0] hi_hit;
	logic [3:0] hrgn;
	logic [7:0] lo_byte;

	assign wr_hit  = rom_wr & cart_download;
	assign lo_byte = rom_data[7:0];
	assign lo_hit  = letter_hit(lo_byte);
	assign hi_hit  = letter_hit(rom_data[15:8]);
	assign hrgn    = rom_data[3:0] - 4'd7; // hex letter code to value

	always_comb begin
		flags_nxt = flags;
		if (wr_hit && rom_addr == `GEN_HDR_REGION0) begin
			if (|lo_hit) flags_nxt = flags_nxt | lo_hit;
			else if (lo_byte >= "0" && lo_byte <= "9") flags_nxt = {rom_data[0], rom_data[2], rom_data[3]};
			else if (lo_byte >= "A" && lo_byte <= "F") flags_nxt = {hrgn[0], hrgn[2], hrgn[3]};
			flags_nxt = flags_nxt | hi_hit; // second char, letters only
		end
		if (wr_hit && rom_addr == `GEN_HDR_REGION1) flags_nxt = flags_nxt | lo_hit;
	end

	always_ff @(posedge clk_sys or negedge pll_core_locked) begin
		if (!pll_core_locked) begin
			flags       <= 3'b000;
			header_done <= 1'b0;
			region_req  <= genesis_pkg::US;
		end else begin
			flags       <= load_start ? 3'b000 : flags_nxt;
			header_done <= wr_hit && (rom_addr == `GEN_HDR_END);
			if (region_latch) begin
				if (flags[1])      region_req <= genesis_pkg::US;
				else if (flags[0]) region_req <= genesis_pkg::EU;
				else if (flags[2]) region_req <= genesis_pkg::JP;
				else               region_req <= genesis_pkg::US; // nothing found
			end
		end
	end

endmodule

//--- hw/reset_hold_timer.sv
//////////////////////////////////////////////////////////////////////
// reset hold timer
// keeps the core in reset for a fixed time after a host request
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "genesis_defines.svh"

module reset_hold_timer (
	input  logic clk_sys,
	input  logic pll_core_locked,
	input  logic hold_req,
	output logic busy
);

	localparam int CNT_W = $clog2(`GEN_RESET_HOLD_CYCLES + 1);

	logic [CNT_W-1:0] count;

	always_ff @(posedge clk_sys or negedge pll_core_locked) begin
		if (!pll_core_locked) begin
			count <= '0;
		end else if (hold_req) begin
			count <= CNT_W'(`GEN_RESET_HOLD_CYCLES); // retrigger restarts the hold
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	assign busy = (count != '0);

endmodule

//--- verification/genesis_cart_chk.sv
//////////////////////////////////////////////////////////////////////
// genesis cartridge control checker
// reset, strobe and region assertions bound to the top level
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module genesis_cart_chk (
	input logic       clk_sys,
	input logic       pll_core_locked,
	input logic       region_hold,
	input logic       load_start,
	input logic       core_reset_n,
	input logic [1:0] region_req,
	input logic       timer_busy,
	input logic       hold_req
);

	int unsigned busy_run;
	int unsigned fail_count = 0;

	// busy cycles since the last request
	always_ff @(posedge clk_sys or negedge pll_core_locked) begin
		if (!pll_core_locked) busy_run <= 0;
		else if (hold_req || !timer_busy) busy_run <= 0;
		else busy_run <= busy_run + 1;
	end

	hold_forces_reset: assert property (@(posedge clk_sys) disable iff (!pll_core_locked)
		region_hold |=> !core_reset_n) else begin
		$error("core_reset_n high one cycle after region_hold");
		fail_count++;
	end

	load_start_single: assert property (@(posedge clk_sys) disable iff (!pll_core_locked)
		load_start |=> !load_start) else begin
		$error("load_start longer than one cycle");
		fail_count++;
	end

	region_legal: assert property (@(posedge clk_sys) disable iff (!pll_core_locked)
		region_req != 2'd3) else begin
		$error("region_req holds the unused code 3");
		fail_count++;
	end

	busy_bounded: assert property (@(posedge clk_sys) disable iff (!pll_core_locked)
		busy_run <= 16) else begin
		$error("reset hold timer busy beyond 16 cycles");
		fail_count++;
	end

endmodule

bind genesis_cart_top genesis_cart_chk u_genesis_cart_chk (
	.clk_sys(clk_sys),
	.pll_core_locked(pll_core_locked),
	.region_hold(region_hold),
	.load_start(load_start),
	.core_reset_n(core_reset_n),
	.region_req(region_req),
	.timer_busy(timer_busy),
	.hold_req(hold_req)
);

//--- verification/genesis_cart_tb.sv
//////////////////////////////////////////////////////////////////////
// genesis cartridge control testbench
// directed tests for settings, region detect, quirks and core reset
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "genesis_defines.svh"

module genesis_cart_tb;

	logic clk_sys = 1'b0;
	logic pll_core_locked, bridge_wr, cart_download, rom_wr;
	genesis_pkg::bridge_word_t bridge_addr, bridge_wr_data, bridge_rd_data;
	genesis_pkg::rom_addr_t rom_addr;
	genesis_pkg::rom_word_t rom_data;
	genesis_pkg::region_e region_req;
	logic sram_quirk, eeprom_quirk, noram_quirk, fifo_quirk, svp_quirk, fmbusy_quirk;
	logic [1:0] cpu_turbo, audio_filter;
	logic multitap_en, ar_correction_en, composite_en, obj_limit_high;
	logic fm_enable, psg_enable, hifi_pcm_en, fm_chip, core_reset_n;
	logic [5:0] quirks;
	logic [11:0] settings;
	integer seed = 32'hd6a0_4c5a;
	int errors = 0;
	int failed_tests = 0;
	int test_count = 0;

	assign quirks = {sram_quirk, eeprom_quirk, noram_quirk, fifo_quirk, svp_quirk, fmbusy_quirk};
	assign settings = {cpu_turbo, audio_filter, multitap_en, ar_correction_en, composite_en,
		obj_limit_high, fm_enable, psg_enable, hifi_pcm_en, fm_chip};

	always #10 clk_sys = ~clk_sys;

	genesis_cart_top u_genesis_cart_top (.*);

	task automatic report_mismatch(input string test, input logic [31:0] exp,
		input logic [31:0] act);
		$display("FAILED %s expected %0h actual %0h", test, exp, act);
		errors++;
	endtask

	task automatic finish_test(input string test, input int errors_before);
		test_count++;
		if (errors == errors_before) begin
			$display("test %s: ok", test);
		end else begin
			failed_tests++;
			$display("test %s: %0d errors", test, errors - errors_before);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// bus drivers
	//////////////////////////////////////////////////////////////////////

	task automatic bridge_write(input genesis_pkg::bridge_word_t addr,
		input genesis_pkg::bridge_word_t data);
		bridge_addr    = addr;
		bridge_wr_data = data;
		bridge_wr      = 1'b1;
		@(posedge clk_sys);
		#2;
		bridge_wr = 1'b0;
	endtask

	task automatic bridge_read(input genesis_pkg::bridge_word_t addr,
		output genesis_pkg::bridge_word_t data);
		bridge_addr = addr;
		#8; // sample the combinational read data mid cycle
		data = bridge_rd_data;
		@(posedge clk_sys);
		#2;
	endtask

	task automatic rom_word(input genesis_pkg::rom_addr_t addr, input genesis_pkg::rom_word_t data);
		rom_addr = addr;
		rom_data = data;
		rom_wr   = 1'b1;
		@(posedge clk_sys);
		#2;
		rom_wr = 1'b0;
	endtask

	task automatic wait_core_reset(input logic level, output int cycles);
		cycles = 0;
		while (core_reset_n !== level && cycles < 64) begin
			@(posedge clk_sys);
			#2;
			cycles++;
		end
		if (core_reset_n !== level) begin
			$display("timeout: core_reset_n never reached %b", level);
			errors++;
		end
	endtask

	task automatic start_download;
		cart_download = 1'b1;
		repeat (2) @(posedge clk_sys); // load_start, then decoder clear
		#2;
	endtask

	task automatic end_download(input string test, input int exp_release);
		int cycles;
		cart_download = 1'b0;
		wait_core_reset(1'b1, cycles);
		if (cycles != exp_release) report_mismatch({test, " release"}, exp_release, cycles);
		@(posedge clk_sys); // fsm has to see the download low
		#2;
	endtask

	task automatic region_download(input string test, input genesis_pkg::rom_word_t w0,
		input genesis_pkg::rom_word_t w1, input genesis_pkg::region_e exp);
		int cycles;
		genesis_pkg::bridge_word_t rd;
		start_download();
		rom_word(`GEN_HDR_REGION0, w0);
		rom_word(`GEN_HDR_REGION1, w1);
		rom_word(`GEN_HDR_END, 16'h0000);
		wait_core_reset(1'b0, cycles);
		if (cycles + 1 != 3) report_mismatch({test, " reset delay"}, 3, cycles + 1); // strobe cycle too
		if (region_req !== exp) report_mismatch(test, exp, region_req);
		bridge_read(`GEN_ADDR_REGION, rd);
		if (rd !== 32'(exp)) report_mismatch({test, " readback"}, exp, rd);
		if (core_reset_n !== 1'b0) report_mismatch({test, " hold"}, 0, core_reset_n);
		end_download(test, 2);
	endtask

	task automatic id_download(input string test, input logic [63:0] id, input logic [5:0] exp);
		start_download();
		if (quirks !== 6'b0) report_mismatch({test, " clear"}, 0, quirks);
		rom_word(`GEN_HDR_ID0, {id[63:56], 8'h20});
		for (int k = 0; k < 3; k++) begin
			rom_word(genesis_pkg::rom_addr_t'(`GEN_HDR_ID1 + 2 * k),
				{id[47 - 16 * k -: 8], id[55 - 16 * k -: 8]}); // earlier char in low byte
		end
		rom_word(`GEN_HDR_ID4, {8'h20, id[7:0]});
		rom_word(`GEN_HDR_ID_DONE, 16'($random(seed)));
		if (quirks !== exp) report_mismatch(test, exp, quirks);
		end_download(test, 0);
	endtask

	//////////////////////////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic settings_access;
		int start;
		genesis_pkg::bridge_word_t addrs [10];
		genesis_pkg::bridge_word_t data;
		logic [11:0] exp;
		start = errors;
		addrs = '{`GEN_ADDR_TURBO, `GEN_ADDR_FILTER, `GEN_ADDR_MULTITAP, `GEN_ADDR_AR_CORR,
			`GEN_ADDR_COMPOSITE, `GEN_ADDR_OBJ_LIMIT, `GEN_ADDR_FM, `GEN_ADDR_PSG,
			`GEN_ADDR_HIFI, `GEN_ADDR_FM_CHIP};
		exp = 12'b0000_0001_1110; // obj limit, fm, psg and hifi on
		if (settings !== exp) report_mismatch("settings defaults", exp, settings);
		for (int i = 0; i < 10; i++) begin
			data = $random(seed);
			bridge_write(addrs[i], data);
			if (i < 2) exp[10 - 2 * i +: 2] = data[1:0];
			else exp[9 - i] = data[0];
			if (settings !== exp) report_mismatch("settings write", exp, settings);
		end
		bridge_read(`GEN_ADDR_REGION, data);
		if (data !== 32'd1) report_mismatch("settings region read", 1, data);
		bridge_read(`GEN_ADDR_TURBO, data);
		if (data !== 32'd0) report_mismatch("settings turbo read", 0, data);
		bridge_read(`GEN_ADDR_FM, data);
		if (data !== 32'd0) report_mismatch("settings fm read", 0, data);
		finish_test("settings", start);
	endtask

	task automatic letter_decode;
		int start;
		start = errors;
		region_download("letter U", {8'h20, "U"}, 16'h2020, genesis_pkg::US);
		region_download("letter UE", {"E", "U"}, 16'h2020, genesis_pkg::US);
		region_download("letter E", {8'h20, "E"}, 16'h2020, genesis_pkg::EU);
		region_download("letter J", {8'h20, "J"}, 16'h2020, genesis_pkg::JP);
		region_download("no letter", 16'h2020, 16'h2020, genesis_pkg::US);
		region_download("high byte E", {"E", 8'h20}, 16'h2020, genesis_pkg::EU);
		region_download("second word E", 16'h2020, {8'h20, "E"}, genesis_pkg::EU);
		finish_test("letter decode", start);
	endtask

	task automatic code_decode;
		int start;
		start = errors;
		region_download("code 8", {8'h20, "8"}, 16'h2020, genesis_pkg::EU);
		region_download("code 4", {8'h20, "4"}, 16'h2020, genesis_pkg::US);
		region_download("code 1", {8'h20, "1"}, 16'h2020, genesis_pkg::JP);
		region_download("code A", {8'h20, "A"}, 16'h2020, genesis_pkg::EU); // 1 minus 7 is 1010
		region_download("code C", {8'h20, "C"}, 16'h2020, genesis_pkg::US);
		finish_test("code decode", start);
	endtask

	task automatic quirk_match;
		int start;
		start = errors;
		id_download("quirk sram", "T-081276", 6'b100000);
		id_download("quirk svp", "MK-1229 ", 6'b000010);
		id_download("quirk unknown", "T-12345 ", 6'b000000);
		finish_test("quirk lookup", start);
	endtask

	task automatic reset_hold_req;
		int start;
		int cycles;
		int low_cycles;
		start = errors;
		bridge_write(`GEN_ADDR_RESET, 32'($random(seed)) | 32'h1);
		wait_core_reset(1'b0, cycles);
		if (cycles + 1 != 2) report_mismatch("reset hold delay", 2, cycles + 1);
		wait_core_reset(1'b1, cycles);
		if (cycles != `GEN_RESET_HOLD_CYCLES) report_mismatch("reset hold length", 16, cycles);
		bridge_write(`GEN_ADDR_RESET, 32'h0);
		low_cycles = 0;
		repeat (20) begin
			@(posedge clk_sys);
			#2;
			if (!core_reset_n) low_cycles++;
		end
		if (low_cycles != 0) report_mismatch("reset zero write", 0, low_cycles);
		finish_test("reset hold", start);
	endtask

	initial begin
		int cycles;
		int assert_fails;
		pll_core_locked = 1'b0;
		bridge_wr       = 1'b0;
		bridge_addr     = '0;
		bridge_wr_data  = '0;
		cart_download   = 1'b0;
		rom_wr          = 1'b0;
		rom_addr        = '0;
		rom_data        = '0;
		repeat (4) @(posedge clk_sys);
		#2;
		pll_core_locked = 1'b1;
		wait_core_reset(1'b1, cycles);
		settings_access();
		letter_decode();
		code_decode();
		quirk_match();
		reset_hold_req();
		assert_fails = u_genesis_cart_top.u_genesis_cart_chk.fail_count;
		errors += assert_fails;
		$display("tests %0d, failed tests %0d, assertion failures %0d, errors %0d",
			test_count, failed_tests, assert_fails, errors);
		if (errors == 0) $display("ALL TESTS PASSED");
		else $display("SOME TESTS FAILED");
		$finish;
	end

endmodule
